//--- common/phy_pkg.sv
package phy_pkg;

   // ====================================================================
   // Frame format
   // ====================================================================
   localparam int DATA_W       = 64;  // Line and user word width
   localparam int FRAME_LEN    = 8;   // FAW, six slots, tail
   localparam int SLOTS        = 6;   // Payload slots per frame
   localparam int ALIGN_FRAMES = 4;   // FAW hits needed for alignment
   localparam int FIFO_DEPTH   = 16;  // Both stream FIFOs

   localparam logic [DATA_W-1:0] FAW_PATTERN = 64'h5A3C_96F0_0FF0_C3A5;

   localparam int CRC_W   = 16;  // CRC field width
   localparam int CRC_LSB = 48;  // Tail bits 63..48
   localparam int RDY_BIT = 8;   // Tail bit with sender RX ready

   localparam logic [CRC_W-1:0] CRC_POLY = 16'h1021;
   localparam logic [CRC_W-1:0] CRC_INIT = 16'hFFFF;

   localparam int PHASE_W = $clog2(FRAME_LEN);       // Word position in frame
   localparam int FIFO_AW = $clog2(FIFO_DEPTH);      // FIFO pointer width
   localparam int HIT_W   = $clog2(ALIGN_FRAMES + 1); // FAW hit counter width

   // ====================================================================
   // Status and error codes
   // ====================================================================
   typedef enum logic [3:0] {
      CTRL_RESET       = 4'd0,
      CTRL_TRAIN       = 4'd1,
      CTRL_WAIT_REMOTE = 4'd2,
      CTRL_READY       = 4'd3,
      CTRL_FAULT       = 4'd4
   } ctrl_state_e;

   typedef enum logic [3:0] {
      EC_NONE        = 4'd0,
      EC_FAW_LOST    = 4'd1,
      EC_CRC         = 4'd2,
      EC_RX_OVERFLOW = 4'd3
   } ecode_e;

   // CRC-16 over one line word, MSB first
   function automatic logic [CRC_W-1:0] crc16_word(input logic [CRC_W-1:0] crc_in,
                                                   input logic [DATA_W-1:0] word);
      logic [CRC_W-1:0] crc;
      logic             fb;
      crc = crc_in;
      for (int i = DATA_W - 1; i >= 0; i--) begin
         fb  = crc[CRC_W-1] ^ word[i];  // Feedback bit
         crc = {crc[CRC_W-2:0], 1'b0};
         if (fb) crc = crc ^ CRC_POLY;
      end
      return crc;
   endfunction

endpackage

//--- common/rx_status_if.sv
`timescale 1ns/1ps

interface rx_status_if;
   import phy_pkg::*;

   logic   rx_rdy;      // Decoder aligned
   logic   remote_rdy;  // Last good tail had RDY set
   logic   fault;       // One-cycle fault pulse
   ecode_e fault_code;  // Valid with fault

   modport decoder (output rx_rdy, output remote_rdy, output fault, output fault_code);
   modport ctrl (input rx_rdy, input remote_rdy);
   modport err (input fault, input fault_code);

endinterface

//--- rtl/sync_fifo.sv
`timescale 1ns/1ps

module sync_fifo (
   input  logic                       clk_i,
   input  logic                       rst_i,
   input  logic                       wr_i,        // Write strobe
   input  logic [phy_pkg::DATA_W-1:0] wdata_i,
   input  logic                       rd_i,        // Read strobe, pops head
   output logic [phy_pkg::DATA_W-1:0] rdata_o,     // Head word, shows ahead
   output logic                       full_o,
   output logic                       empty_o,
   output logic                       overflow_o   // Dropped write pulse
);
   import phy_pkg::*;

   logic [DATA_W-1:0]  mem [FIFO_DEPTH];  // Storage
   logic [FIFO_AW-1:0] wr_ptr;            // Next write slot
   logic [FIFO_AW-1:0] rd_ptr;            // Head slot
   logic [FIFO_AW:0]   count;             // Words held
   logic               do_wr;
   logic               do_rd;

   assign full_o  = (count == (FIFO_AW + 1)'(FIFO_DEPTH));
   assign empty_o = (count == '0);
   assign do_wr   = wr_i && !full_o;   // Write while full is lost
   assign do_rd   = rd_i && !empty_o;
   assign rdata_o = mem[rd_ptr];       // Next word after a pop

   always_ff @(posedge clk_i) begin
      if (do_wr) mem[wr_ptr] <= wdata_i;
   end

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         wr_ptr     <= '0;
         rd_ptr     <= '0;
         count      <= '0;
         overflow_o <= 1'b0;
      end else begin
         if (do_wr) wr_ptr <= wr_ptr + 1'b1;  // Depth is a power of two
         if (do_rd) rd_ptr <= rd_ptr + 1'b1;
         count      <= count + (FIFO_AW + 1)'(do_wr) - (FIFO_AW + 1)'(do_rd);
         overflow_o <= wr_i && full_o;
      end
   end

   a_full_empty: assert property (@(posedge clk_i) disable iff (rst_i)
      !(full_o && empty_o));

endmodule

//--- tx_encoder/phy_tx_encoder.sv
`timescale 1ns/1ps

module phy_tx_encoder (
   input  logic                       clk_i,
   input  logic                       rst_i,
   input  logic                       link_enable_i,  // Send frames
   input  logic                       data_enable_i,  // Slots may carry data
   input  logic                       local_rdy_i,    // Our RX aligned
   input  logic [phy_pkg::DATA_W-1:0] fifo_rdata_i,
   input  logic                       fifo_empty_i,
   output logic                       fifo_rd_o,
   output logic [phy_pkg::DATA_W-1:0] line_tx_o
);
   import phy_pkg::*;

   logic [PHASE_W-1:0]   cnt_q;      // Word position in frame
   logic [CRC_W-1:0]     crc_q;      // Running CRC over slots
   logic [FRAME_LEN-1:0] mask_q;     // Bit per frame position
   logic                 is_slot;
   logic [DATA_W-1:0]    slot_word;  // Data or idle zeros
   logic [DATA_W-1:0]    tail_word;

   assign is_slot   = link_enable_i && (cnt_q != '0) && (cnt_q <= PHASE_W'(SLOTS));
   assign fifo_rd_o = is_slot && data_enable_i && !fifo_empty_i;
   assign slot_word = fifo_rd_o ? fifo_rdata_i : '0;

   always_comb begin
      tail_word                    = '0;
      tail_word[CRC_LSB +: CRC_W]  = crc_q;             // CRC in top bits
      tail_word[RDY_BIT]           = local_rdy_i;
      tail_word[SLOTS-1:0]         = mask_q[SLOTS:1];   // Slot k+1 in bit k
   end

   // Line word register, frame starts when link enable rises
   always_ff @(posedge clk_i) begin
      if (rst_i || !link_enable_i) begin
         cnt_q     <= '0;
         line_tx_o <= '0;
      end else begin
         cnt_q <= cnt_q + 1'b1;  // Wraps at FRAME_LEN
         if (cnt_q == '0) line_tx_o <= FAW_PATTERN;
         else if (is_slot) line_tx_o <= slot_word;
         else line_tx_o <= tail_word;
      end
   end

   // CRC and mask restart at every FAW
   always_ff @(posedge clk_i) begin
      if (cnt_q == '0) begin
         crc_q  <= CRC_INIT;
         mask_q <= '0;
      end else if (is_slot) begin
         crc_q         <= crc16_word(crc_q, slot_word);  // Idle slots included
         mask_q[cnt_q] <= fifo_rd_o;
      end
   end

   a_rd_data_en: assert property (@(posedge clk_i) disable iff (rst_i)
      fifo_rd_o |-> data_enable_i);

endmodule

//--- rx_decoder/phy_rx_decoder.sv
`timescale 1ns/1ps

module phy_rx_decoder (
   input  logic                       clk_i,
   input  logic                       rst_i,
   input  logic [phy_pkg::DATA_W-1:0] line_rx_i,
   output logic                       fifo_wr_o,     // No back-pressure
   output logic [phy_pkg::DATA_W-1:0] fifo_wdata_o,
   rx_status_if.decoder               status
);
   import phy_pkg::*;

   logic [PHASE_W-1:0]   phase_q;        // Position of incoming word
   logic [HIT_W-1:0]     hits_q;         // Consecutive FAW hits
   logic                 tracking_q;     // Candidate frame phase held
   logic                 aligned_q;
   logic                 verdict_q;      // Previous frame passed CRC
   logic [FRAME_LEN-1:0] mask_q;         // Valid slots of previous frame
   logic [CRC_W-1:0]     crc_q;
   logic [DATA_W-1:0]    dly_q [FRAME_LEN];  // One frame of line words
   logic                 is_faw;
   logic                 frame_start;
   logic                 in_slot;
   logic                 at_tail;

   assign is_faw         = (line_rx_i == FAW_PATTERN);
   assign frame_start    = tracking_q && (phase_q == '0);
   assign in_slot        = aligned_q && (phase_q != '0) && (phase_q <= PHASE_W'(SLOTS));
   assign at_tail        = aligned_q && (phase_q == PHASE_W'(FRAME_LEN - 1));
   assign status.rx_rdy  = aligned_q;

   // ====================================================================
   // Frame alignment
   // ====================================================================
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         phase_q    <= '0;
         hits_q     <= '0;
         tracking_q <= 1'b0;
         aligned_q  <= 1'b0;
      end else begin
         phase_q <= phase_q + 1'b1;  // Free running
         if (!tracking_q && is_faw) begin
            tracking_q <= 1'b1;         // Lock phase on first hit
            hits_q     <= HIT_W'(1);
            phase_q    <= PHASE_W'(1);
         end else if (frame_start) begin
            if (is_faw) begin
               if (!aligned_q) hits_q <= hits_q + 1'b1;
               if (hits_q == HIT_W'(ALIGN_FRAMES - 1)) aligned_q <= 1'b1;
            end else begin
               tracking_q <= 1'b0;      // Back to hunting
               aligned_q  <= 1'b0;
               hits_q     <= '0;
            end
         end
      end
   end

   // ====================================================================
   // Frame check
   // ====================================================================
   always_ff @(posedge clk_i) begin
      if (phase_q == '0) crc_q <= CRC_INIT;
      else if (in_slot) crc_q <= crc16_word(crc_q, line_rx_i);
   end

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         verdict_q         <= 1'b0;
         mask_q            <= '0;
         status.remote_rdy <= 1'b0;
         status.fault      <= 1'b0;
         status.fault_code <= EC_NONE;
      end else begin
         status.fault <= 1'b0;  // Pulse by default
         if (aligned_q && frame_start && !is_faw) begin
            status.fault      <= 1'b1;
            status.fault_code <= EC_FAW_LOST;
            verdict_q         <= 1'b0;
            status.remote_rdy <= 1'b0;
         end else if (at_tail) begin
            if (crc_q != line_rx_i[CRC_LSB +: CRC_W]) begin
               status.fault      <= 1'b1;
               status.fault_code <= EC_CRC;
               verdict_q         <= 1'b0;  // Discard this frame
            end else begin
               verdict_q         <= 1'b1;
               mask_q            <= {1'b0, line_rx_i[SLOTS-1:0], 1'b0};
               status.remote_rdy <= line_rx_i[RDY_BIT];
            end
         end
      end
   end

   // Slot words leave one frame later at the same phase, gated by verdict
   always_ff @(posedge clk_i) begin
      dly_q[0] <= line_rx_i;
      for (int i = 1; i < FRAME_LEN; i++) dly_q[i] <= dly_q[i-1];
   end

   assign fifo_wdata_o = dly_q[FRAME_LEN-1];
   assign fifo_wr_o    = verdict_q && mask_q[phase_q];

   a_wr_aligned: assert property (@(posedge clk_i) disable iff (rst_i)
      fifo_wr_o |-> status.rx_rdy);

endmodule

//--- rtl/phy_link_controller.sv
`timescale 1ns/1ps

module phy_link_controller (
   input  logic                 clk_i,
   input  logic                 rst_i,
   input  logic                 fault_fatal_i,  // From error handler
   rx_status_if.ctrl            status,
   output logic                 link_enable_o,  // Encoder sends frames
   output logic                 data_enable_o,  // Slots may carry data
   output logic                 link_ready_o,
   output phy_pkg::ctrl_state_e status_o
);
   import phy_pkg::*;

   ctrl_state_e state_q;
   ctrl_state_e state_d;

   // Link bring-up FSM
   always_comb begin
      state_d = state_q;
      case (state_q)
         CTRL_RESET:       state_d = CTRL_TRAIN;
         CTRL_TRAIN:       if (status.rx_rdy) state_d = CTRL_WAIT_REMOTE;
         CTRL_WAIT_REMOTE: if (status.remote_rdy) state_d = CTRL_READY;
         default:          state_d = state_q;  // READY and FAULT hold
      endcase
      if (fault_fatal_i) state_d = CTRL_FAULT;  // Only reset leaves FAULT
   end

   always_ff @(posedge clk_i) begin
      if (rst_i) state_q <= CTRL_RESET;
      else state_q <= state_d;
   end

   assign link_enable_o = (state_q != CTRL_RESET) && (state_q != CTRL_FAULT);
   assign data_enable_o = (state_q == CTRL_READY);
   assign link_ready_o  = (state_q == CTRL_READY);
   assign status_o      = state_q;  // State doubles as status code

   a_data_needs_link: assert property (@(posedge clk_i) disable iff (rst_i)
      data_enable_o |-> link_enable_o);

endmodule

//--- rtl/phy_error_handler.sv
`timescale 1ns/1ps

module phy_error_handler (
   input  logic            clk_i,
   input  logic            rst_i,
   input  logic            rx_overflow_i,  // RX FIFO dropped a word
   rx_status_if.err        status,
   output logic            fault_fatal_o,
   output phy_pkg::ecode_e ecode_o
);
   import phy_pkg::*;

   // First fault wins, held until reset
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         fault_fatal_o <= 1'b0;
         ecode_o       <= EC_NONE;
      end else if (!fault_fatal_o) begin
         if (status.fault) begin  // Decoder first on a tie
            fault_fatal_o <= 1'b1;
            ecode_o       <= status.fault_code;
         end else if (rx_overflow_i) begin
            fault_fatal_o <= 1'b1;
            ecode_o       <= EC_RX_OVERFLOW;
         end
      end
   end

endmodule

//--- rtl/phy_link_top.sv
`timescale 1ns/1ps

module phy_link_top (
   input  logic                       clk_i,
   input  logic                       rst_i,
   // ====================================================================
   // User streams
   // ====================================================================
   input  logic [phy_pkg::DATA_W-1:0] tx_tdata_i,
   input  logic                       tx_tvalid_i,
   output logic                       tx_tready_o,
   output logic [phy_pkg::DATA_W-1:0] rx_tdata_o,
   output logic                       rx_tvalid_o,
   input  logic                       rx_tready_i,
   // ====================================================================
   // Status and line
   // ====================================================================
   output logic [3:0]                 status_o,       // Link state code
   output logic [3:0]                 ecode_o,        // First error code
   output logic                       link_ready_o,
   output logic                       fault_fatal_o,
   output logic [phy_pkg::DATA_W-1:0] line_tx_o,
   input  logic [phy_pkg::DATA_W-1:0] line_rx_i
);

   logic                       link_enable;
   logic                       data_enable;
   logic                       tx_fifo_wr;
   logic                       tx_fifo_rd;
   logic                       tx_fifo_full;
   logic                       tx_fifo_empty;
   logic [phy_pkg::DATA_W-1:0] tx_fifo_rdata;
   logic                       rx_fifo_wr;
   logic                       rx_fifo_rd;
   logic                       rx_fifo_empty;
   logic                       rx_fifo_overflow;
   logic [phy_pkg::DATA_W-1:0] rx_fifo_wdata;

   rx_status_if rx_status ();  // Decoder to controller and error handler

   // Stream gating
   assign tx_tready_o = !tx_fifo_full && data_enable;
   assign tx_fifo_wr  = tx_tvalid_i && tx_tready_o;
   assign rx_tvalid_o = !rx_fifo_empty && link_ready_o;
   assign rx_fifo_rd  = rx_tvalid_o && rx_tready_i;

   sync_fifo i_tx_fifo (
      .clk_i(clk_i), .rst_i(rst_i),
      .wr_i(tx_fifo_wr), .wdata_i(tx_tdata_i),
      .rd_i(tx_fifo_rd), .rdata_o(tx_fifo_rdata),
      .full_o(tx_fifo_full), .empty_o(tx_fifo_empty),
      .overflow_o()                                    // Ready gating prevents it
   );

   phy_tx_encoder i_phy_tx_encoder (
      .clk_i(clk_i), .rst_i(rst_i),
      .link_enable_i(link_enable), .data_enable_i(data_enable),
      .local_rdy_i(rx_status.rx_rdy),                  // Sent in every tail
      .fifo_rdata_i(tx_fifo_rdata), .fifo_empty_i(tx_fifo_empty),
      .fifo_rd_o(tx_fifo_rd), .line_tx_o(line_tx_o)
   );

   phy_rx_decoder i_phy_rx_decoder (
      .clk_i(clk_i), .rst_i(rst_i), .line_rx_i(line_rx_i),
      .fifo_wr_o(rx_fifo_wr), .fifo_wdata_o(rx_fifo_wdata),
      .status(rx_status.decoder)
   );

   sync_fifo i_rx_fifo (
      .clk_i(clk_i), .rst_i(rst_i),
      .wr_i(rx_fifo_wr), .wdata_i(rx_fifo_wdata),
      .rd_i(rx_fifo_rd), .rdata_o(rx_tdata_o),
      .full_o(), .empty_o(rx_fifo_empty),
      .overflow_o(rx_fifo_overflow)                    // Fatal, logged below
   );

   phy_link_controller i_phy_link_controller (
      .clk_i(clk_i), .rst_i(rst_i), .fault_fatal_i(fault_fatal_o),
      .status(rx_status.ctrl),
      .link_enable_o(link_enable), .data_enable_o(data_enable),
      .link_ready_o(link_ready_o), .status_o(status_o)
   );

   phy_error_handler i_phy_error_handler (
      .clk_i(clk_i), .rst_i(rst_i), .rx_overflow_i(rx_fifo_overflow),
      .status(rx_status.err),
      .fault_fatal_o(fault_fatal_o), .ecode_o(ecode_o)
   );

endmodule

//--- bench/phy_link_tb.sv
`timescale 1ns/1ps

module phy_link_tb;
   import phy_pkg::*;

   // ====================================================================
   // Run limits and stimulus settings
   // ====================================================================
   localparam int CLK_PERIOD   = 4;
   localparam int RESET_CYC    = 8;
   localparam int BRING_UP_CYC = (ALIGN_FRAMES + 4) * FRAME_LEN;  // Alignment plus remote tail
   localparam int LINE_FRAMES  = 6;
   localparam int LINE_CYC     = (LINE_FRAMES + 2) * FRAME_LEN;
   localparam int DATA_WORDS   = 200;
   localparam int DATA_CYC     = 8 * DATA_WORDS;
   localparam int FAULT_CYC    = 4 * FRAME_LEN;  // Injection to fatal flag
   localparam int OVF_CYC      = 8 * FIFO_DEPTH;
   localparam int TOTAL_CYC    = 6 * (RESET_CYC + BRING_UP_CYC) + LINE_CYC + DATA_CYC
                                 + 2 * (FAULT_CYC + 2 * FRAME_LEN) + OVF_CYC;
   localparam int WATCHDOG_NS  = 2 * TOTAL_CYC * CLK_PERIOD;
   localparam logic [31:0] SEED = 32'hc38f_fc78;

   localparam int MODE_IDLE   = 0;  // Idle TX and ready RX
   localparam int MODE_RANDOM = 1;  // Random valid and ready
   localparam int MODE_FLOOD  = 2;  // TX always valid with RX stalled

   logic              clk;
   logic              rst;
   logic [DATA_W-1:0] tx_tdata;
   logic              tx_tvalid;
   logic              tx_tready;
   logic [DATA_W-1:0] rx_tdata;
   logic              rx_tvalid;
   logic              rx_tready;
   logic [3:0]        status;
   logic [3:0]        ecode;
   logic              link_ready;
   logic              fault_fatal;
   logic [DATA_W-1:0] line_tx;
   logic [DATA_W-1:0] line_rx;
   logic [DATA_W-1:0] inj_mask;   // XOR on the loopback word
   logic [31:0]       lcg_state;
   logic [31:0]       rnd;
   logic              tx_fire;    // TX transfer at next rising edge
   int                tx_left;    // TX words still to be accepted
   int                drv_mode;
   logic [DATA_W-1:0] model_q [$];  // Accepted TX words in order

   phy_link_top i_phy_link_top (
      .clk_i(clk), .rst_i(rst),
      .tx_tdata_i(tx_tdata), .tx_tvalid_i(tx_tvalid), .tx_tready_o(tx_tready),
      .rx_tdata_o(rx_tdata), .rx_tvalid_o(rx_tvalid), .rx_tready_i(rx_tready),
      .status_o(status), .ecode_o(ecode),
      .link_ready_o(link_ready), .fault_fatal_o(fault_fatal),
      .line_tx_o(line_tx), .line_rx_i(line_rx)
   );

   always #(CLK_PERIOD / 2) clk = ~clk;

   function automatic logic [31:0] lcg_next();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   function automatic logic [DATA_W-1:0] rand_word();
      logic [31:0] hi;
      logic [31:0] lo;
      hi = lcg_next();
      lo = lcg_next();
      return {hi, lo};
   endfunction

   // Bit-serial CRC-16 with the word MSB first
   function automatic logic [CRC_W-1:0] model_crc(input logic [CRC_W-1:0] c,
                                                  input logic [DATA_W-1:0] w);
      logic [CRC_W-1:0] r;
      r = c;
      for (int b = DATA_W - 1; b >= 0; b--) begin
         if (r[CRC_W-1] != w[b]) r = (r << 1) ^ CRC_POLY;
         else r = r << 1;
      end
      return r;
   endfunction

   task automatic abort_run(input string why);
      $display("%s", why);
      $display("TEST FAIL");
      $fatal(1);
   endtask

   task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
      if (got !== exp)
         abort_run($sformatf("Mismatch at %0t ns: %s got %0h expected %0h",
                             $time, name, got, exp));
   endtask

   // ====================================================================
   // Loopback, stream driver and scoreboard
   // ====================================================================
   always @(posedge clk) line_rx <= line_tx ^ inj_mask;  // One-cycle line delay

   always @(posedge clk) begin
      rnd = lcg_next();
      case (drv_mode)
         MODE_RANDOM: begin
            if (!tx_tvalid || tx_fire) begin  // Hold a word until taken
               tx_tdata  <= rand_word();
               tx_tvalid <= (tx_left > 0) && rnd[0];
            end
            rx_tready <= (rnd[3:1] != 3'd0);  // Ready 7 of 8 cycles
         end
         MODE_FLOOD: begin
            if (!tx_tvalid || tx_fire) tx_tdata <= rand_word();
            tx_tvalid <= 1'b1;
            rx_tready <= 1'b0;
         end
         default: begin
            tx_tvalid <= 1'b0;
            rx_tready <= 1'b1;
         end
      endcase
   end

   always @(negedge clk) begin
      tx_fire = tx_tvalid && tx_tready;
      if (tx_fire) begin
         model_q.push_back(tx_tdata);
         if (tx_left > 0) tx_left--;
      end
      if (rx_tvalid && rx_tready) begin
         if (model_q.size() == 0) abort_run("RX stream delivered a word that was never sent");
         else check_val("rx_tdata_o", rx_tdata, model_q.pop_front());
      end
   end

   initial begin
      #(WATCHDOG_NS);
      abort_run("Watchdog expired before the tests finished");
   end

   // ====================================================================
   // Test steps
   // ====================================================================
   task automatic reset_dut();
      drv_mode = MODE_IDLE;
      inj_mask = '0;
      @(posedge clk);
      rst <= 1'b1;
      repeat (RESET_CYC) @(posedge clk);
      rst <= 1'b0;
      model_q.delete();
      tx_left = 0;
      @(negedge clk);
   endtask

   task automatic bring_up();
      int n;
      reset_dut();
      check_val("status_o", status, CTRL_RESET);  // Outputs idle after reset
      check_val("link_ready_o", link_ready, 1'b0);
      check_val("tx_tready_o", tx_tready, 1'b0);
      check_val("rx_tvalid_o", rx_tvalid, 1'b0);
      check_val("fault_fatal_o", fault_fatal, 1'b0);
      check_val("ecode_o", ecode, EC_NONE);
      check_val("line_tx_o", line_tx, '0);
      n = 0;
      while (!link_ready) begin
         if (n == BRING_UP_CYC) abort_run("Link did not come up within the cycle bound");
         else begin
            @(negedge clk);
            n++;
         end
      end
      check_val("status_o", status, CTRL_READY);
      check_val("ecode_o", ecode, EC_NONE);
   endtask

   task automatic find_faw();
      int n;
      n = 0;
      while (line_tx != FAW_PATTERN) begin
         if (n == 2 * FRAME_LEN) abort_run("No frame alignment word found on line_tx_o");
         else begin
            @(negedge clk);
            n++;
         end
      end
   endtask

   task automatic wait_fatal(input int bound);
      int n;
      n = 0;
      while (!fault_fatal) begin
         if (n == bound) abort_run("fault_fatal_o did not rise after the injected error");
         else begin
            @(negedge clk);
            n++;
         end
      end
   endtask

   // Flip bits of the word at a given frame position on its way back
   task automatic corrupt_word(input int offset, input logic [DATA_W-1:0] flip);
      find_faw();
      repeat (offset) @(negedge clk);
      inj_mask = flip;  // Taken by the loopback at the next rising edge
      @(negedge clk);
      inj_mask = '0;
   endtask

   task automatic test_line_format();
      logic [CRC_W-1:0]  crc;
      logic [SLOTS-1:0]  mask;
      logic [DATA_W-1:0] w;
      logic              seen_data;
      bring_up();
      tx_left  = 1000;
      drv_mode = MODE_RANDOM;
      seen_data = 1'b0;
      find_faw();
      for (int f = 0; f < LINE_FRAMES; f++) begin
         check_val("line_tx_o FAW", line_tx, FAW_PATTERN);
         crc  = CRC_INIT;
         mask = '0;
         for (int s = 0; s < SLOTS; s++) begin
            @(negedge clk);
            w       = line_tx;
            crc     = model_crc(crc, w);
            mask[s] = (w != '0);  // Idle slots are all zeros
         end
         @(negedge clk);
         w = line_tx;
         check_val("tail CRC", w[CRC_LSB +: CRC_W], crc);
         check_val("tail mask", w[SLOTS-1:0], mask);
         check_val("tail RDY", w[RDY_BIT], 1'b1);
         if (mask != '0) seen_data = 1'b1;
         @(negedge clk);
      end
      check_val("frames carrying data", seen_data, 1'b1);
      drv_mode = MODE_IDLE;
   endtask

   task automatic test_data();
      int n;
      bring_up();
      tx_left  = DATA_WORDS;
      drv_mode = MODE_RANDOM;
      n = 0;
      while (tx_left != 0 || model_q.size() != 0) begin
         if (n == DATA_CYC) abort_run("Not every sent word came back on the RX stream");
         else begin
            @(posedge clk);
            n++;
         end
      end
      @(negedge clk);
      drv_mode = MODE_IDLE;
      check_val("fault_fatal_o", fault_fatal, 1'b0);
      check_val("ecode_o", ecode, EC_NONE);
   endtask

   task automatic test_crc_fault();
      logic [31:0] r;
      int          offset;
      int          bitpos;
      bring_up();
      r      = lcg_next();
      offset = 1 + r % 7;  // A slot or the tail
      bitpos = (offset == FRAME_LEN - 1) ? CRC_LSB + r[11:8] : r[21:16];
      corrupt_word(offset, 64'd1 << bitpos);
      wait_fatal(FAULT_CYC);
      check_val("ecode_o", ecode, EC_CRC);
      @(negedge clk);
      check_val("status_o", status, CTRL_FAULT);
      check_val("link_ready_o", link_ready, 1'b0);
      check_val("tx_tready_o", tx_tready, 1'b0);
   endtask

   task automatic test_faw_loss();
      logic [31:0] r;
      bring_up();
      r = lcg_next();
      corrupt_word(0, 64'd1 << r[5:0]);
      wait_fatal(FAULT_CYC);
      check_val("ecode_o", ecode, EC_FAW_LOST);
      repeat (FRAME_LEN) @(negedge clk);
      check_val("fault_fatal_o", fault_fatal, 1'b1);  // Held until reset
      check_val("ecode_o", ecode, EC_FAW_LOST);
   endtask

   task automatic test_overflow();
      bring_up();
      drv_mode = MODE_FLOOD;
      wait_fatal(OVF_CYC);
      check_val("ecode_o", ecode, EC_RX_OVERFLOW);
      @(posedge clk);
      check_val("words accepted above depth", model_q.size() > FIFO_DEPTH, 1'b1);
      @(negedge clk);
      drv_mode = MODE_IDLE;
      repeat (2 * FRAME_LEN) @(negedge clk);  // Silent line trips FAW loss
      check_val("fault_fatal_o", fault_fatal, 1'b1);
      check_val("ecode_o", ecode, EC_RX_OVERFLOW);
   endtask

   initial begin
      clk       = 1'b0;
      rst       = 1'b1;
      tx_tdata  = '0;
      tx_tvalid = 1'b0;
      rx_tready = 1'b0;
      line_rx   = '0;
      inj_mask  = '0;
      tx_fire   = 1'b0;
      tx_left   = 0;
      drv_mode  = MODE_IDLE;
      lcg_state = SEED;
      bring_up();          // Bring-up checks only
      test_line_format();
      test_data();
      test_crc_fault();
      test_faw_loss();
      test_overflow();
      $display("TEST PASS");
      $finish;
   end

endmodule

//--- phy_link_top.f
common/phy_pkg.sv
common/rx_status_if.sv
rtl/sync_fifo.sv
tx_encoder/phy_tx_encoder.sv
rx_decoder/phy_rx_decoder.sv
rtl/phy_link_controller.sv
rtl/phy_error_handler.sv
rtl/phy_link_top.sv
bench/phy_link_tb.sv

//--- Bender.yml
package:
  name: phy_link

sources:
  - common/phy_pkg.sv
  - common/rx_status_if.sv
  - rtl/sync_fifo.sv
  - tx_encoder/phy_tx_encoder.sv
  - rx_decoder/phy_rx_decoder.sv
  - rtl/phy_link_controller.sv
  - rtl/phy_error_handler.sv
  - rtl/phy_link_top.sv
  - target: test
    files:
      - bench/phy_link_tb.sv
